/* bench/tb_kbd_model.svh */
`ifndef TB_KBD_MODEL_SVH
`define TB_KBD_MODEL_SVH

// ==================================================
// Key tables of the ABC80 keyboard
// ==================================================

typedef struct packed {
	logic      hit;
	abc_char_t code;
} ref_result_t;

// Scancodes of A..Z in alphabet order
localparam logic [7:0] LETTER_SC [0:25] = '{
	8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
	8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
	8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
localparam logic [7:0] NAT_SC  [0:4] = '{8'h55, 8'h54, 8'h5B, 8'h4C, 8'h52};
localparam abc_char_t  NAT_CHR [0:4] = '{7'h40, 7'h5D, 7'h5E, 7'h5C, 7'h5B};

// Digits in the order 1..9, 0
localparam logic [7:0] TOP_SC    [0:9] = '{8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
	8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45};
localparam logic [7:0] KP_SC     [0:9] = '{8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73,
	8'h74, 8'h6C, 8'h75, 8'h7D, 8'h70};
localparam abc_char_t  DIGIT_CHR [0:9] = '{7'h31, 7'h32, 7'h33, 7'h34, 7'h35,
	7'h36, 7'h37, 7'h38, 7'h39, 7'h30};
localparam abc_char_t  SHDIG_CHR [0:9] = '{7'h21, 7'h22, 7'h23, 7'h24, 7'h25,
	7'h26, 7'h27, 7'h28, 7'h29, 7'h3D};

localparam logic [7:0] PUNCT_SC    [0:5] = '{8'h41, 8'h49, 8'h4A, 8'h4E, 8'h5D, 8'h0E};
localparam abc_char_t  PUNCT_CHR   [0:5] = '{7'h2C, 7'h2E, 7'h2D, 7'h2B, 7'h27, 7'h3C};
localparam abc_char_t  SHPUNCT_CHR [0:5] = '{7'h3B, 7'h3A, 7'h5F, 7'h3F, 7'h2A, 7'h3E};

// Expected translation of one event under the given modifiers
function automatic ref_result_t ref_xlat(input modifiers_t m, input ps2_event_t e);
	ref_result_t r;
	r = '0;
	if (m.ctrl) begin // Only break keys and DEL under ctrl
		if (!e.extended && e.code == 8'h21 && !m.shift) r = '{1'b1, CHR_ETX};
		if (!e.extended && e.code == 8'h22 && !m.shift) r = '{1'b1, CHR_CAN};
		if (!e.extended && e.code == 8'h0E) r = '{1'b1, CHR_DEL};
		return r;
	end
	if (e.extended) begin
		if (!m.shift && e.code == SC_ENTER) r = '{1'b1, CHR_CR};
		if (!m.shift && e.code == SC_LEFT) r = '{1'b1, CHR_BS};
		if (!m.shift && e.code == SC_RIGHT) r = '{1'b1, CHR_HT};
		return r;
	end
	for (int i = 0; i < 26; i++)
		if (e.code == LETTER_SC[i]) r = '{1'b1, 7'(65 + i)};
	for (int i = 0; i < 5; i++)
		if (e.code == NAT_SC[i]) r = '{1'b1, NAT_CHR[i]};
	if (r.hit) begin
		r.code[CASE_BIT] = (m.shift == m.upcase); // Lower case when they agree
		return r;
	end
	for (int i = 0; i < 10; i++) begin
		if (e.code == TOP_SC[i]) r = '{1'b1, m.shift ? SHDIG_CHR[i] : DIGIT_CHR[i]};
		if (e.code == KP_SC[i] && !m.shift) r = '{1'b1, DIGIT_CHR[i]};
	end
	for (int i = 0; i < 6; i++)
		if (e.code == PUNCT_SC[i]) r = '{1'b1, m.shift ? SHPUNCT_CHR[i] : PUNCT_CHR[i]};
	if (!m.shift && e.code == SC_ENTER) r = '{1'b1, CHR_CR};
	if (!m.shift && e.code == SC_SPACE) r = '{1'b1, CHR_SP};
	if (!m.shift && e.code == SC_BKSP) r = '{1'b1, CHR_BS};
	return r;
endfunction

// Shift and ctrl follow the key, caps toggles on press
function automatic modifiers_t mods_after(input modifiers_t m, input ps2_event_t e);
	modifiers_t n;
	n = m;
	if (!e.extended && (e.code == SC_LSHIFT || e.code == SC_RSHIFT)) n.shift = e.pressed;
	if (e.code == SC_CTRL) n.ctrl = e.pressed;
	if (!e.extended && e.code == SC_CAPS && e.pressed) n.upcase = !m.upcase;
	return n;
endfunction

// ==================================================
// Compare tasks
// ==================================================

task automatic check_port(input string name, input key_port_t got, input key_port_t exp);
	if (got !== exp) begin
		port_errs++;
		$display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		bit_errs++;
		$display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		count_errs++;
		$display("CHECK FAILED t=%0t %s got %0d exp %0d", $time, name, got, exp);
	end
endtask

`endif

/* bench/tb_abc80_keyboard.sv */
module tb_abc80_keyboard;
	import ps2_pkg::*;
	import abc80_kbd_pkg::*;

	localparam logic [TIMER_W-1:0] T_FIRST  = 24'd40;
	localparam logic [TIMER_W-1:0] T_REPEAT = 24'd20;
	localparam logic [TIMER_W-1:0] T_PULSE  = 24'd6;
	localparam int TIMEOUT_CYCLES = 4000; // Tests need about 2000 cycles

	// Extra keys as {extended, code}, the last three unmapped
	localparam logic [8:0] EXTRA_KEYS [0:8] = '{9'h05A, 9'h029, 9'h066, 9'h15A,
		9'h16B, 9'h174, 9'h005, 9'h076, 9'h11C};
	// Random pool mixes mapped keys and modifiers
	localparam logic [7:0] POOL [0:15] = '{8'h1C, 8'h21, 8'h22, 8'h16, 8'h45, 8'h69,
		8'h6B, 8'h74, 8'h5A, 8'h29, 8'h0E, 8'h55, 8'h12, 8'h59, 8'h14, 8'h58};

	logic       CLK12;
	logic       RESET;
	logic       key_strobe;
	ps2_event_t key_event;
	key_port_t  key_port;
	logic       upcase;

	int port_errs = 0;
	int bit_errs = 0;
	int count_errs = 0;
	int cycle_cnt = 0;
	logic [31:0] lfsr = 32'hbbb3_0586;

	// Model state
	modifiers_t exp_mods;
	abc_char_t  exp_kcode;
	logic       exp_held;
	logic       held_prev;
	logic       rep_active;
	int         since_pulse;
	int         pulse_gap;

	`include "tb_kbd_model.svh"

	abc80_keyboard #(
		.FIRST_DELAY  (T_FIRST),
		.REPEAT_DELAY (T_REPEAT),
		.PULSE_LEN    (T_PULSE)
	) uut (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_strobe (key_strobe),
		.key_event  (key_event),
		.key_port   (key_port),
		.upcase     (upcase)
	);

	initial CLK12 = 1'b0;
	always #50 CLK12 = ~CLK12;

	// ==================================================
	// Model update at the edge, compare before the next
	// ==================================================

	always @(posedge CLK12) begin : compare_proc
		ref_result_t r;
		key_port_t   exp_port;
		if (RESET) begin
			exp_mods = '0;
			exp_kcode = '0;
			exp_held = 1'b0;
			held_prev = 1'b0;
			rep_active = 1'b0;
			since_pulse = 0;
			pulse_gap = 0;
		end else begin
			if (exp_held && !held_prev) begin // New press
				rep_active = 1'b1;
				since_pulse = 0;
				pulse_gap = int'(T_FIRST) + 1;
			end else if (rep_active) begin
				since_pulse++;
				if (since_pulse == pulse_gap) begin
					if (exp_held) begin
						since_pulse = 0;
						pulse_gap = int'(T_REPEAT) + 1;
					end else begin
						rep_active = 1'b0;
					end
				end
			end
			held_prev = exp_held;
			if (key_strobe) begin
				r = ref_xlat(exp_mods, key_event); // Modifiers from before this edge
				if (r.hit) begin
					exp_held = key_event.pressed;
					exp_kcode = r.code;
				end
				exp_mods = mods_after(exp_mods, key_event);
			end
		end
		#90;
		exp_port.keydown = rep_active && (since_pulse <= int'(T_PULSE));
		exp_port.kcode = exp_kcode;
		check_port("key_port", key_port, exp_port);
		check_bit("upcase", upcase, exp_mods.upcase);
	end

	always @(posedge CLK12) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_counts();
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic report_counts();
		$display("Errors: port %0d, upcase %0d, timing %0d", port_errs, bit_errs, count_errs);
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	task automatic send_event(input logic prs, input logic ext, input logic [7:0] code);
		@(posedge CLK12);
		#10;
		key_strobe = 1'b1;
		key_event = {prs, ext, code};
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK12);
			#10;
			key_strobe = 1'b0;
		end
	endtask

	task automatic tap(input logic ext, input logic [7:0] code);
		send_event(1'b1, ext, code);
		send_event(1'b0, ext, code);
	endtask

	task automatic set_mods(input logic sh, input logic ct, input logic up);
		if (exp_mods.upcase != up)
			tap(1'b0, SC_CAPS);
		if (sh)
			send_event(1'b1, 1'b0, SC_LSHIFT);
		if (ct)
			send_event(1'b1, 1'b1, SC_CTRL); // Right ctrl
		idle(1);
	endtask

	task automatic type_all_keys();
		for (int i = 0; i < 26; i++) tap(1'b0, LETTER_SC[i]);
		for (int i = 0; i < 5; i++) tap(1'b0, NAT_SC[i]);
		for (int i = 0; i < 10; i++) tap(1'b0, TOP_SC[i]);
		for (int i = 0; i < 10; i++) tap(1'b0, KP_SC[i]);
		for (int i = 0; i < 6; i++) tap(1'b0, PUNCT_SC[i]);
		for (int i = 0; i < 9; i++) tap(EXTRA_KEYS[i][8], EXTRA_KEYS[i][7:0]);
	endtask

	// Cycles until keydown rises, -1 if it does not within limit
	task automatic wait_rise(input int limit, output int cycles);
		logic prev;
		prev = key_port.keydown;
		cycles = -1;
		for (int n = 1; n <= limit; n++) begin
			@(posedge CLK12);
			#10;
			key_strobe = 1'b0; // Ends a strobe still pending
			#40;
			if (key_port.keydown && !prev) begin
				cycles = n;
				return;
			end
			prev = key_port.keydown;
		end
	endtask

	initial begin : main
		int n;
		int high;
		logic up0;
		logic [7:0] idx;
		logic [7:0] x;
		logic [7:0] p;
		logic [7:0] g;
		RESET = 1'b1;
		key_strobe = 1'b0;
		key_event = '0;
		repeat (8) @(posedge CLK12);
		#10;
		RESET = 1'b0;
		idle(1);
		check_port("key_port after reset", key_port, '0);
		check_bit("upcase after reset", upcase, 1'b0);

		for (int c = 0; c < 8; c++) begin // Every shift, ctrl, upcase mix
			set_mods(c[0], c[1], c[2]);
			type_all_keys();
			send_event(1'b0, 1'b0, SC_LSHIFT);
			send_event(1'b0, 1'b0, SC_CTRL);
			idle(1);
		end

		for (int k = 0; k < 3; k++) begin // Caps-lock toggle
			up0 = exp_mods.upcase;
			send_event(1'b1, 1'b0, SC_CAPS);
			idle(2);
			check_bit("upcase after caps press", upcase, !up0);
			send_event(1'b0, 1'b0, SC_CAPS);
			idle(2);
			check_bit("upcase after caps release", upcase, !up0);
			tap(1'b0, LETTER_SC[k]);
			idle(1);
		end

		// ==================================================
		// Key-down pulse and auto-repeat
		// ==================================================

		idle(60);
		tap(1'b0, 8'h32);
		wait_rise(10, n);
		check_count("keydown rise after short press", n, 1);
		high = 1;
		while (key_port.keydown && high < 20) begin
			@(posedge CLK12);
			#50;
			if (key_port.keydown) high++;
		end
		check_count("keydown pulse length", high, int'(T_PULSE) + 1);
		wait_rise(60, n);
		check_count("extra pulse after short press", n, -1);

		send_event(1'b1, 1'b0, 8'h15);
		idle(1);
		wait_rise(10, n);
		check_count("keydown rise on held key", n, 1);
		wait_rise(60, n);
		check_count("first repeat distance", n, int'(T_FIRST) + 1);
		for (int k = 0; k < 2; k++) begin
			wait_rise(40, n);
			check_count("repeat period", n, int'(T_REPEAT) + 1);
		end
		send_event(1'b0, 1'b0, 8'h15);
		idle(1);
		wait_rise(int'(T_FIRST) + int'(T_REPEAT), n);
		check_count("pulse after release", n, -1);

		for (int k = 0; k < 300; k++) begin // Random events
			take_bits(4, idx);
			take_bits(2, x);
			take_bits(1, p);
			take_bits(1, g);
			send_event(p[0], x[1:0] == 2'b00, POOL[idx[3:0]]);
			if (g[0])
				idle(1);
		end
		idle(5);

		report_counts();
		if (port_errs + bit_errs + count_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* common/abc80_kbd_pkg.sv */
// ==================================================
// ABC80 side of the keyboard path
// ==================================================

package abc80_kbd_pkg;

	// 7-bit character code as seen on PIO port A
	typedef logic [6:0] abc_char_t;

	// Word read by the computer on port A
	typedef struct packed {
		logic      keydown; // Bit 7, strobe level
		abc_char_t kcode;   // Bits 6..0
	} key_port_t;

	// Keyboard state that changes the translation
	typedef struct packed {
		logic shift;
		logic ctrl;
		logic upcase; // Caps-lock toggle, also shown on a LED
	} modifiers_t;

	// Lower-case bit inside a letter code
	localparam int CASE_BIT = 5;

	// ==================================================
	// Control characters
	// ==================================================

	localparam abc_char_t CHR_ETX = 7'h03; // Ctrl+C, break
	localparam abc_char_t CHR_BS  = 7'h08; // Backspace and cursor left
	localparam abc_char_t CHR_HT  = 7'h09; // Cursor right
	localparam abc_char_t CHR_CR  = 7'h0D;
	localparam abc_char_t CHR_CAN = 7'h18; // Ctrl+X, line cancel
	localparam abc_char_t CHR_SP  = 7'h20;
	localparam abc_char_t CHR_DEL = 7'h7F;

	// ==================================================
	// Auto-repeat timing in CLK12 cycles
	// ==================================================

	localparam int TIMER_W = 24;

	// About 167 ms before the first repeat
	localparam logic [TIMER_W-1:0] FIRST_DELAY  = 24'd2_000_000;
	// About 42 ms between repeats
	localparam logic [TIMER_W-1:0] REPEAT_DELAY = 24'd500_000;
	// About 25 ms of keydown per pulse
	localparam logic [TIMER_W-1:0] PULSE_LEN    = 24'd300_000;

endpackage

/* common/ps2_pkg.sv */
// ==================================================
// PS/2 side of the keyboard path
// ==================================================

package ps2_pkg;

	// One deserialized key event, valid with its strobe
	typedef struct packed {
		logic       pressed;  // Make (1) or break (0)
		logic       extended; // E0 prefix seen
		logic [7:0] code;     // Set 2 scancode
	} ps2_event_t;

	// ==================================================
	// Modifier and toggle keys
	// ==================================================

	localparam logic [7:0] SC_LSHIFT = 8'h12;
	localparam logic [7:0] SC_RSHIFT = 8'h59;
	localparam logic [7:0] SC_CTRL   = 8'h14; // Left and right (E0) ctrl share it
	localparam logic [7:0] SC_CAPS   = 8'h58;

	// ==================================================
	// Special keys
	// ==================================================

	localparam logic [7:0] SC_ENTER  = 8'h5A; // Main and keypad enter
	localparam logic [7:0] SC_SPACE  = 8'h29;
	localparam logic [7:0] SC_BKSP   = 8'h66;
	localparam logic [7:0] SC_LEFT   = 8'h6B; // Extended only
	localparam logic [7:0] SC_RIGHT  = 8'h74; // Extended only

	// Without the E0 prefix these two codes are keypad 4 and 6,
	// so the extended flag has to be part of every match

endpackage

/* hw/abc80_keyboard.sv */
module abc80_keyboard #(
	parameter logic [abc80_kbd_pkg::TIMER_W-1:0] FIRST_DELAY  = abc80_kbd_pkg::FIRST_DELAY,
	parameter logic [abc80_kbd_pkg::TIMER_W-1:0] REPEAT_DELAY = abc80_kbd_pkg::REPEAT_DELAY,
	parameter logic [abc80_kbd_pkg::TIMER_W-1:0] PULSE_LEN    = abc80_kbd_pkg::PULSE_LEN
) (
	input  logic                     CLK12,
	input  logic                     RESET,
	input  logic                     key_strobe,
	input  ps2_pkg::ps2_event_t      key_event,
	output abc80_kbd_pkg::key_port_t key_port,
	output logic                     upcase
);

	abc80_kbd_pkg::modifiers_t mods;
	abc80_kbd_pkg::abc_char_t  kcode;
	logic                      held;
	logic                      keydown;

	modifier_tracker u_mods (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_strobe (key_strobe),
		.key_event  (key_event),
		.mods       (mods)
	);

	scancode_translator u_xlat (
		.CLK12      (CLK12),
		.RESET      (RESET),
		.key_strobe (key_strobe),
		.key_event  (key_event),
		.mods       (mods),
		.held       (held),
		.kcode      (kcode)
	);

	key_repeat #(
		.FIRST_DELAY  (FIRST_DELAY),
		.REPEAT_DELAY (REPEAT_DELAY),
		.PULSE_LEN    (PULSE_LEN)
	) u_rep (
		.CLK12   (CLK12),
		.RESET   (RESET),
		.held    (held),
		.keydown (keydown)
	);

	// PIO port A word
	assign key_port = '{keydown: keydown, kcode: kcode};
	assign upcase   = mods.upcase;

endmodule

/* keyboard/key_repeat.sv */
module key_repeat #(
	parameter logic [abc80_kbd_pkg::TIMER_W-1:0] FIRST_DELAY  = abc80_kbd_pkg::FIRST_DELAY,
	parameter logic [abc80_kbd_pkg::TIMER_W-1:0] REPEAT_DELAY = abc80_kbd_pkg::REPEAT_DELAY,
	parameter logic [abc80_kbd_pkg::TIMER_W-1:0] PULSE_LEN    = abc80_kbd_pkg::PULSE_LEN
) (
	input  logic CLK12,
	input  logic RESET,
	input  logic held,
	output logic keydown
);
	import abc80_kbd_pkg::*;

	logic               held_d;
	logic               press;
	logic [TIMER_W-1:0] pulse_cnt; // Remaining keydown cycles
	logic [TIMER_W-1:0] rep_cnt;   // Cycles until next repeat

	assign press = held && !held_d;

	// ==================================================
	// Pulse and repeat counters
	// ==================================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			held_d    <= 1'b0;
			keydown   <= 1'b0;
			pulse_cnt <= '0;
			rep_cnt   <= '0;
		end else begin
			held_d <= held;

			if (|pulse_cnt)
				pulse_cnt <= pulse_cnt - 1'b1;
			else
				keydown <= 1'b0; // Pulse finished

			// New press wins over a running pulse
			if (press) begin
				keydown   <= 1'b1;
				rep_cnt   <= FIRST_DELAY;
				pulse_cnt <= PULSE_LEN;
			end else if (|rep_cnt) begin
				rep_cnt <= rep_cnt - 1'b1;
			end else if (held) begin
				keydown   <= 1'b1; // Auto-repeat
				rep_cnt   <= REPEAT_DELAY;
				pulse_cnt <= PULSE_LEN;
			end else begin
				keydown   <= 1'b0; // Released and timed out
				pulse_cnt <= '0;
			end
		end
	end

endmodule

/* keyboard/modifier_tracker.sv */
module modifier_tracker (
	input  logic                      CLK12,
	input  logic                      RESET,
	input  logic                      key_strobe,
	input  ps2_pkg::ps2_event_t       key_event,
	output abc80_kbd_pkg::modifiers_t mods
);
	import ps2_pkg::*;
	import abc80_kbd_pkg::*;

	logic       is_shift;
	logic       is_ctrl;
	logic       is_caps;
	modifiers_t mods_next;

	// Shift and caps are plain codes, ctrl matches either way
	assign is_shift = !key_event.extended &&
	                  (key_event.code == SC_LSHIFT || key_event.code == SC_RSHIFT);
	assign is_ctrl  = (key_event.code == SC_CTRL);
	assign is_caps  = !key_event.extended && (key_event.code == SC_CAPS);

	always_comb begin
		mods_next = mods;
		if (key_strobe) begin
			if (is_shift)
				mods_next.shift = key_event.pressed; // Level follows the key
			if (is_ctrl)
				mods_next.ctrl = key_event.pressed;
			if (is_caps && key_event.pressed)
				mods_next.upcase = !mods.upcase; // Break code ignored
		end
	end

	always_ff @(posedge CLK12) begin
		if (RESET)
			mods <= '0;
		else
			mods <= mods_next;
	end

endmodule

/* keyboard/scancode_translator.sv */
module scancode_translator (
	input  logic                      CLK12,
	input  logic                      RESET,
	input  logic                      key_strobe,
	input  ps2_pkg::ps2_event_t       key_event,
	input  abc80_kbd_pkg::modifiers_t mods,
	output logic                      held,
	output abc80_kbd_pkg::abc_char_t  kcode
);
	import ps2_pkg::*;
	import abc80_kbd_pkg::*;

	// One table lookup result
	typedef struct packed {
		logic      hit;
		logic      alpha; // Case follows shift and upcase
		abc_char_t code;
	} xlat_t;

	localparam xlat_t MISS = '{hit: 1'b0, alpha: 1'b0, code: '0};

	logic [10:0] sel;
	xlat_t       xl;
	abc_char_t   next_code;

	function automatic xlat_t plain(input abc_char_t c);
		return '{hit: 1'b1, alpha: 1'b0, code: c};
	endfunction

	function automatic xlat_t letter(input abc_char_t c);
		return '{hit: 1'b1, alpha: 1'b1, code: c};
	endfunction

	assign sel = {mods.ctrl, mods.shift, key_event.extended, key_event.code};

	// ==================================================
	// Key table, first match wins
	// ==================================================

	always_comb begin
		xl = MISS;
		casez (sel)
			{2'b0?, 1'b0, 8'h1C}: xl = letter(7'h41); // A
			{2'b0?, 1'b0, 8'h32}: xl = letter(7'h42); // B
			{2'b0?, 1'b0, 8'h21}: xl = letter(7'h43); // C
			{2'b0?, 1'b0, 8'h23}: xl = letter(7'h44); // D
			{2'b0?, 1'b0, 8'h24}: xl = letter(7'h45); // E
			{2'b0?, 1'b0, 8'h2B}: xl = letter(7'h46); // F
			{2'b0?, 1'b0, 8'h34}: xl = letter(7'h47); // G
			{2'b0?, 1'b0, 8'h33}: xl = letter(7'h48); // H
			{2'b0?, 1'b0, 8'h43}: xl = letter(7'h49); // I
			{2'b0?, 1'b0, 8'h3B}: xl = letter(7'h4A); // J
			{2'b0?, 1'b0, 8'h42}: xl = letter(7'h4B); // K
			{2'b0?, 1'b0, 8'h4B}: xl = letter(7'h4C); // L
			{2'b0?, 1'b0, 8'h3A}: xl = letter(7'h4D); // M
			{2'b0?, 1'b0, 8'h31}: xl = letter(7'h4E); // N
			{2'b0?, 1'b0, 8'h44}: xl = letter(7'h4F); // O
			{2'b0?, 1'b0, 8'h4D}: xl = letter(7'h50); // P
			{2'b0?, 1'b0, 8'h15}: xl = letter(7'h51); // Q
			{2'b0?, 1'b0, 8'h2D}: xl = letter(7'h52); // R
			{2'b0?, 1'b0, 8'h1B}: xl = letter(7'h53); // S
			{2'b0?, 1'b0, 8'h2C}: xl = letter(7'h54); // T
			{2'b0?, 1'b0, 8'h3C}: xl = letter(7'h55); // U
			{2'b0?, 1'b0, 8'h2A}: xl = letter(7'h56); // V
			{2'b0?, 1'b0, 8'h1D}: xl = letter(7'h57); // W
			{2'b0?, 1'b0, 8'h22}: xl = letter(7'h58); // X
			{2'b0?, 1'b0, 8'h35}: xl = letter(7'h59); // Y
			{2'b0?, 1'b0, 8'h1A}: xl = letter(7'h5A); // Z

			{2'b00, 1'b0, 8'h16}: xl = plain(7'h31); // Top row digits
			{2'b00, 1'b0, 8'h1E}: xl = plain(7'h32);
			{2'b00, 1'b0, 8'h26}: xl = plain(7'h33);
			{2'b00, 1'b0, 8'h25}: xl = plain(7'h34);
			{2'b00, 1'b0, 8'h2E}: xl = plain(7'h35);
			{2'b00, 1'b0, 8'h36}: xl = plain(7'h36);
			{2'b00, 1'b0, 8'h3D}: xl = plain(7'h37);
			{2'b00, 1'b0, 8'h3E}: xl = plain(7'h38);
			{2'b00, 1'b0, 8'h46}: xl = plain(7'h39);
			{2'b00, 1'b0, 8'h45}: xl = plain(7'h30);

			{2'b00, 1'b0, 8'h69}: xl = plain(7'h31); // Keypad digits
			{2'b00, 1'b0, 8'h72}: xl = plain(7'h32);
			{2'b00, 1'b0, 8'h7A}: xl = plain(7'h33);
			{2'b00, 1'b0, 8'h6B}: xl = plain(7'h34);
			{2'b00, 1'b0, 8'h73}: xl = plain(7'h35);
			{2'b00, 1'b0, 8'h74}: xl = plain(7'h36);
			{2'b00, 1'b0, 8'h6C}: xl = plain(7'h37);
			{2'b00, 1'b0, 8'h75}: xl = plain(7'h38);
			{2'b00, 1'b0, 8'h7D}: xl = plain(7'h39);
			{2'b00, 1'b0, 8'h70}: xl = plain(7'h30);

			{2'b01, 1'b0, 8'h16}: xl = plain(7'h21); // Shifted digits, Swedish layout
			{2'b01, 1'b0, 8'h1E}: xl = plain(7'h22);
			{2'b01, 1'b0, 8'h26}: xl = plain(7'h23);
			{2'b01, 1'b0, 8'h25}: xl = plain(7'h24);
			{2'b01, 1'b0, 8'h2E}: xl = plain(7'h25);
			{2'b01, 1'b0, 8'h36}: xl = plain(7'h26);
			{2'b01, 1'b0, 8'h3D}: xl = plain(7'h27);
			{2'b01, 1'b0, 8'h3E}: xl = plain(7'h28);
			{2'b01, 1'b0, 8'h46}: xl = plain(7'h29);
			{2'b01, 1'b0, 8'h45}: xl = plain(7'h3D);

			{2'b00, 1'b?, SC_ENTER}: xl = plain(CHR_CR);
			{2'b00, 1'b0, SC_SPACE}: xl = plain(CHR_SP);
			{2'b00, 1'b1, SC_LEFT}:  xl = plain(CHR_BS);
			{2'b00, 1'b0, SC_BKSP}:  xl = plain(CHR_BS);
			{2'b00, 1'b1, SC_RIGHT}: xl = plain(CHR_HT);
			{2'b10, 1'b0, 8'h21}:    xl = plain(CHR_ETX); // Ctrl+C
			{2'b10, 1'b0, 8'h22}:    xl = plain(CHR_CAN); // Ctrl+X

			{2'b00, 1'b0, 8'h41}: xl = plain(7'h2C); // Comma
			{2'b00, 1'b0, 8'h49}: xl = plain(7'h2E); // Period
			{2'b00, 1'b0, 8'h4A}: xl = plain(7'h2D); // Minus
			{2'b00, 1'b0, 8'h4E}: xl = plain(7'h2B); // Plus
			{2'b00, 1'b0, 8'h5D}: xl = plain(7'h27); // Apostrophe
			{2'b00, 1'b0, 8'h0E}: xl = plain(7'h3C); // Key left of 1
			{2'b01, 1'b0, 8'h41}: xl = plain(7'h3B);
			{2'b01, 1'b0, 8'h49}: xl = plain(7'h3A);
			{2'b01, 1'b0, 8'h4A}: xl = plain(7'h5F);
			{2'b01, 1'b0, 8'h4E}: xl = plain(7'h3F);
			{2'b01, 1'b0, 8'h5D}: xl = plain(7'h2A);
			{2'b01, 1'b0, 8'h0E}: xl = plain(7'h3E);
			{2'b1?, 1'b0, 8'h0E}: xl = plain(CHR_DEL);

			{2'b0?, 1'b0, 8'h55}: xl = letter(7'h40); // E acute
			{2'b0?, 1'b0, 8'h54}: xl = letter(7'h5D); // A ring
			{2'b0?, 1'b0, 8'h5B}: xl = letter(7'h5E); // U umlaut
			{2'b0?, 1'b0, 8'h4C}: xl = letter(7'h5C); // O umlaut
			{2'b0?, 1'b0, 8'h52}: xl = letter(7'h5B); // A umlaut
			default:              xl = MISS;
		endcase
	end

	// Lower case when shift and upcase agree
	always_comb begin
		next_code = xl.code;
		if (xl.alpha)
			next_code[CASE_BIT] = (mods.shift == mods.upcase);
	end

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			held  <= 1'b0;
			kcode <= '0;
		end else if (key_strobe && xl.hit) begin
			held  <= key_event.pressed; // Break of any mapped key releases
			kcode <= next_code;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log && \
verilator --binary --timing -f src.f --top-module tb_abc80_keyboard \
	--Mdir obj_dir -o sim_tb > build.log 2>&1 && \
./obj_dir/sim_tb > sim.log 2>&1 || \
echo "Build or simulation ended abnormally, see build.log and sim.log"

cat sim.log 2>/dev/null

grep -qx "STATUS: PASS" sim.log 2>/dev/null && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

/* src.f */
+incdir+bench
common/ps2_pkg.sv
common/abc80_kbd_pkg.sv
keyboard/modifier_tracker.sv
keyboard/scancode_translator.sv
keyboard/key_repeat.sv
hw/abc80_keyboard.sv
bench/tb_abc80_keyboard.sv
